// File: rtl/mips_pkg.sv
package mips_pkg;

    // primary opcodes, instruction bits 31:26
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_regimm  = 6'b000001;
    localparam logic [5:0] op_jal     = 6'b000011;
    localparam logic [5:0] op_beq     = 6'b000100;
    localparam logic [5:0] op_bgtz    = 6'b000111;
    localparam logic [5:0] op_addiu   = 6'b001001;
    localparam logic [5:0] op_lui     = 6'b001111;
    localparam logic [5:0] op_lbu     = 6'b100100;
    localparam logic [5:0] op_sb      = 6'b101000;

    // funct codes under op_special, bits 5:0
    localparam logic [5:0] fn_jr   = 6'b001000;
    localparam logic [5:0] fn_addu = 6'b100001;
    localparam logic [5:0] fn_subu = 6'b100011;

    // rt code under op_regimm that picks bgez
    localparam logic [4:0] rt_bgez = 5'b00001;

    // split instruction word
    // fields overlap in the source word, each one kept on its own
    typedef struct packed {
        // bits 31:26
        logic [5:0]  opcode;
        // bits 25:21
        logic [4:0]  rs;
        // bits 20:16
        logic [4:0]  rt;
        // bits 15:11
        logic [4:0]  rd;
        // bits 5:0
        logic [5:0]  funct;
        // bits 15:0
        logic [15:0] imm16;
        // bits 25:0, jump index
        logic [25:0] address_26;
    } instr_fields_t;

    // control bits for the later stages
    typedef struct packed {
        // write back to register file
        logic reg_write;
        // data memory read
        logic mem_read;
        // data memory write
        logic mem_write;
        // byte-sized memory access
        logic mem_byte;
        // second alu operand from imm16
        logic alu_src_imm;
        // alu subtracts
        logic alu_sub;
        // imm16 goes to the upper half
        logic imm_upper;
        // destination is rd rather than rt
        logic reg_dst_rd;
        // write return address to r31
        logic link;
        // branch when rs == rt
        logic branch_eq;
        // branch when rs > 0
        logic branch_gtz;
        // branch when rs >= 0
        logic branch_gez;
        // jump to rs
        logic jump_reg;
    } ctrl_t;

    // decoder output bundle
    typedef struct packed {
        instr_fields_t fields;
        ctrl_t         ctrl;
        // encoding outside the supported subset
        logic          illegal;
        // absolute jump through address_26
        logic          jump;
    } decoded_t;

endpackage

// File: rtl/pc_unit.sv
`timescale 1ns/10ps

module pc_unit #(
    parameter int PC_WIDTH = 9
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                run,
    input  logic                stall,
    input  logic                redirect,
    input  logic [PC_WIDTH-1:0] redirect_target,
    output logic [PC_WIDTH-1:0] pc
);

    // next fetch address
    logic [PC_WIDTH-1:0] pc_next;

    // redirect first, then stall, then step by one word
    always_comb begin
        pc_next = pc;
        if (redirect) begin
            pc_next = redirect_target;
        end else if (run && !stall) begin
            pc_next = pc + PC_WIDTH'(1);
        end
    end

    // word address, starts at zero
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // redirect takes effect on the very next fetch
    redirect_loads_target: assert property (
        @(posedge clk) disable iff (reset)
        redirect |=> (pc == $past(redirect_target))
    ) else $error("pc did not load redirect target");

endmodule

// File: rtl/instr_mem.sv
`timescale 1ns/10ps

module instr_mem #(
    parameter int PC_WIDTH = 9
) (
    input  logic                clk,
    input  logic                load_valid,
    input  logic [PC_WIDTH-1:0] load_addr,
    input  logic [31:0]         load_data,
    input  logic [PC_WIDTH-1:0] pc,
    output logic [31:0]         fetch_word
);

    // one word per pc value
    localparam int DEPTH = 2 ** PC_WIDTH;

    // program store, filled through the load port before run
    logic [31:0] mem [DEPTH];

    // load strobe writes one word per edge
    always_ff @(posedge clk) begin
        if (load_valid) begin
            mem[load_addr] <= load_data;
        end
    end

    // asynchronous read at the current pc
    // word lands in IF/ID at the same edge the pc moves on
    assign fetch_word = mem[pc];

endmodule

// File: rtl/ifid_stage.sv
`timescale 1ns/10ps

module ifid_stage #(
    parameter int PC_WIDTH = 9
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   le,
    input  logic                   flush,
    input  logic [31:0]            fetch_word,
    input  logic [PC_WIDTH-1:0]    pc,
    output logic                   id_valid,
    output logic [PC_WIDTH-1:0]    id_pc,
    output logic [31:0]            id_word,
    output mips_pkg::instr_fields_t id_fields
);

    // fields of the incoming word
    mips_pkg::instr_fields_t fields_next;

    // plain bit slices, no dependence on the opcode
    always_comb begin
        fields_next.opcode     = fetch_word[31:26];
        fields_next.rs         = fetch_word[25:21];
        fields_next.rt         = fetch_word[20:16];
        fields_next.rd         = fetch_word[15:11];
        fields_next.funct      = fetch_word[5:0];
        fields_next.imm16      = fetch_word[15:0];
        fields_next.address_26 = fetch_word[25:0];
    end

    // flush beats le so a redirect always leaves a bubble
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_valid  <= 1'b0;
            id_pc     <= '0;
            id_word   <= '0;
            id_fields <= '0;
        end else if (flush) begin
            // zero bubble, decodes as nop
            id_valid  <= 1'b0;
            id_pc     <= '0;
            id_word   <= '0;
            id_fields <= '0;
        end else if (le) begin
            id_valid  <= 1'b1;
            id_pc     <= pc;
            id_word   <= fetch_word;
            id_fields <= fields_next;
        end
    end

    // held word must survive a stall untouched
    hold_when_idle: assert property (
        @(posedge clk) disable iff (reset)
        (!le && !flush) |=> $stable({id_valid, id_pc, id_word, id_fields})
    ) else $error("IF/ID changed without le or flush");

endmodule

// File: rtl/decode_unit.sv
`timescale 1ns/10ps

module decode_unit #(
    parameter int PC_WIDTH = 9
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic                    id_valid,
    input  logic [PC_WIDTH-1:0]     id_pc,
    input  mips_pkg::instr_fields_t id_fields,
    output logic                    dec_valid,
    output mips_pkg::decoded_t      dec,
    output logic [PC_WIDTH-1:0]     dec_pc,
    output logic [PC_WIDTH-1:0]     branch_target,
    output logic [PC_WIDTH-1:0]     jump_target
);

    // combinational decode of the IF/ID word
    mips_pkg::ctrl_t    ctrl_next;
    logic               illegal_next;
    logic               jump_next;
    mips_pkg::decoded_t dec_next;

    // sign-extended offset for branches
    logic [31:0]         imm_sext;
    logic [PC_WIDTH-1:0] branch_next;
    logic [PC_WIDTH-1:0] jump_next_target;

    // hand a result forward only for a valid, unstalled word
    logic issue;

    assign issue = id_valid && !stall;

    always_comb begin
        ctrl_next    = '0;
        illegal_next = 1'b0;
        jump_next    = 1'b0;
        case (id_fields.opcode)
            mips_pkg::op_addiu: begin
                ctrl_next.reg_write   = 1'b1;
                ctrl_next.alu_src_imm = 1'b1;
            end
            mips_pkg::op_lui: begin
                ctrl_next.reg_write   = 1'b1;
                ctrl_next.alu_src_imm = 1'b1;
                ctrl_next.imm_upper   = 1'b1;
            end
            mips_pkg::op_lbu: begin
                ctrl_next.reg_write   = 1'b1;
                ctrl_next.mem_read    = 1'b1;
                ctrl_next.mem_byte    = 1'b1;
                ctrl_next.alu_src_imm = 1'b1;
            end
            mips_pkg::op_sb: begin
                ctrl_next.mem_write   = 1'b1;
                ctrl_next.mem_byte    = 1'b1;
                ctrl_next.alu_src_imm = 1'b1;
            end
            mips_pkg::op_bgtz: begin
                ctrl_next.branch_gtz = 1'b1;
            end
            mips_pkg::op_beq: begin
                // compare by subtraction in the alu
                ctrl_next.branch_eq = 1'b1;
                ctrl_next.alu_sub   = 1'b1;
            end
            mips_pkg::op_jal: begin
                ctrl_next.reg_write = 1'b1;
                ctrl_next.link      = 1'b1;
                jump_next           = 1'b1;
            end
            mips_pkg::op_regimm: begin
                // only bgez in this subset
                if (id_fields.rt == mips_pkg::rt_bgez) begin
                    ctrl_next.branch_gez = 1'b1;
                end else begin
                    illegal_next = 1'b1;
                end
            end
            mips_pkg::op_special: begin
                case (id_fields.funct)
                    mips_pkg::fn_addu: begin
                        ctrl_next.reg_write  = 1'b1;
                        ctrl_next.reg_dst_rd = 1'b1;
                    end
                    mips_pkg::fn_subu: begin
                        ctrl_next.reg_write  = 1'b1;
                        ctrl_next.reg_dst_rd = 1'b1;
                        ctrl_next.alu_sub    = 1'b1;
                    end
                    mips_pkg::fn_jr: begin
                        ctrl_next.jump_reg = 1'b1;
                    end
                    default: begin
                        // all-zero word is nop, anything else unsupported
                        illegal_next = (id_fields.address_26 != '0);
                    end
                endcase
            end
            default: begin
                illegal_next = 1'b1;
            end
        endcase
    end

    // pc + 1 + offset, wraps at the store size
    assign imm_sext         = {{16{id_fields.imm16[15]}}, id_fields.imm16};
    assign branch_next      = id_pc + PC_WIDTH'(1) + imm_sext[PC_WIDTH-1:0];
    assign jump_next_target = id_fields.address_26[PC_WIDTH-1:0];

    always_comb begin
        dec_next.fields  = id_fields;
        dec_next.ctrl    = ctrl_next;
        dec_next.illegal = illegal_next;
        dec_next.jump    = jump_next;
    end

    // strobe and control bundle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dec_valid <= 1'b0;
            dec       <= '0;
        end else begin
            dec_valid <= issue;
            if (issue) begin
                dec <= dec_next;
            end
        end
    end

    // pc and targets, only meaningful under dec_valid
    always_ff @(posedge clk) begin
        if (issue) begin
            dec_pc        <= id_pc;
            branch_target <= branch_next;
            jump_target   <= jump_next_target;
        end
    end

    // the execute stage sees at most one kind of control transfer
    one_transfer: assert property (
        @(posedge clk) disable iff (reset)
        dec_valid |-> $onehot0({dec.ctrl.branch_eq, dec.ctrl.branch_gtz,
                                dec.ctrl.branch_gez, dec.jump})
    ) else $error("more than one branch or jump flag set");

endmodule

// File: rtl/mips_front_end.sv
`timescale 1ns/10ps

module mips_front_end #(
    parameter int PC_WIDTH = 9
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                load_valid,
    input  logic [PC_WIDTH-1:0] load_addr,
    input  logic [31:0]         load_data,
    input  logic                run,
    input  logic                stall,
    input  logic                redirect,
    input  logic [PC_WIDTH-1:0] redirect_target,
    output logic                dec_valid,
    output mips_pkg::decoded_t  dec,
    output logic [PC_WIDTH-1:0] dec_pc,
    output logic [PC_WIDTH-1:0] branch_target,
    output logic [PC_WIDTH-1:0] jump_target
);

    // fetch path
    logic [PC_WIDTH-1:0] pc;
    logic [31:0]         fetch_word;

    // IF/ID contents
    logic                    le;
    logic                    id_valid;
    logic [PC_WIDTH-1:0]     id_pc;
    mips_pkg::instr_fields_t id_fields;

    // IF/ID loads whenever the pc advances
    assign le = run && !stall;

    pc_unit #(.PC_WIDTH(PC_WIDTH)) pc_unit_inst (
        .clk             (clk),
        .reset           (reset),
        .run             (run),
        .stall           (stall),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .pc              (pc)
    );

    instr_mem #(.PC_WIDTH(PC_WIDTH)) instr_mem_inst (
        .clk        (clk),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .pc         (pc),
        .fetch_word (fetch_word)
    );

    // redirect squashes the word fetched in the same cycle
    ifid_stage #(.PC_WIDTH(PC_WIDTH)) ifid_stage_inst (
        .clk        (clk),
        .reset      (reset),
        .le         (le),
        .flush      (redirect),
        .fetch_word (fetch_word),
        .pc         (pc),
        .id_valid   (id_valid),
        .id_pc      (id_pc),
        .id_word    (),
        .id_fields  (id_fields)
    );

    decode_unit #(.PC_WIDTH(PC_WIDTH)) decode_unit_inst (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .id_valid      (id_valid),
        .id_pc         (id_pc),
        .id_fields     (id_fields),
        .dec_valid     (dec_valid),
        .dec           (dec),
        .dec_pc        (dec_pc),
        .branch_target (branch_target),
        .jump_target   (jump_target)
    );

endmodule

// File: verification/mips_front_end_tb.sv
`timescale 1ns/10ps

module mips_front_end_tb;

    localparam int PC_WIDTH = 9;
    // cycle limit for every wait loop
    localparam int TIMEOUT = 100;

    logic                clk = 1'b0;
    logic                reset;
    logic                load_valid;
    logic [PC_WIDTH-1:0] load_addr;
    logic [31:0]         load_data;
    logic                run;
    logic                stall;
    logic                redirect;
    logic [PC_WIDTH-1:0] redirect_target;
    logic                dec_valid;
    mips_pkg::decoded_t  dec;
    logic [PC_WIDTH-1:0] dec_pc;
    logic [PC_WIDTH-1:0] branch_target;
    logic [PC_WIDTH-1:0] jump_target;

    // program image, always loaded from address 0
    logic [31:0] prog[$];
    logic [31:0] lfsr_state = 32'h45c8;
    int          checks = 0;
    int          errors = 0;

    // 8 ns period
    always #4 clk = ~clk;

    mips_front_end #(.PC_WIDTH(PC_WIDTH)) mips_front_end_inst (.*);

    // fibonacci lfsr, one step per returned bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            // taps 32, 22, 2, 1
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic check_ctrl(input string name, input mips_pkg::ctrl_t exp,
                              input mips_pkg::ctrl_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s expected 0x%h, got 0x%h", name, exp, got);
        end
    endtask

    task automatic check_fields(input string name, input mips_pkg::instr_fields_t exp,
                                input mips_pkg::instr_fields_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s expected 0x%h, got 0x%h", name, exp, got);
        end
    endtask

    task automatic check_pc(input string name, input logic [PC_WIDTH-1:0] exp,
                            input logic [PC_WIDTH-1:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s expected 0x%h, got 0x%h", name, exp, got);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s expected 0x%h, got 0x%h", name, exp, got);
        end
    endtask

    // reference decode from the rule table, returns {illegal, jump, ctrl}
    // ctrl columns: wr mr mw by im su up rd lk eq gt ge jr
    function automatic logic [14:0] expected_decode(input logic [31:0] w);
        // all-zero word is nop
        if (w == 32'h0) return '0;
        case (w[31:26])
            mips_pkg::op_addiu: return {2'b00, 13'b1_0_0_0_1_0_0_0_0_0_0_0_0};
            mips_pkg::op_lui:   return {2'b00, 13'b1_0_0_0_1_0_1_0_0_0_0_0_0};
            mips_pkg::op_lbu:   return {2'b00, 13'b1_1_0_1_1_0_0_0_0_0_0_0_0};
            mips_pkg::op_sb:    return {2'b00, 13'b0_0_1_1_1_0_0_0_0_0_0_0_0};
            mips_pkg::op_bgtz:  return {2'b00, 13'b0_0_0_0_0_0_0_0_0_0_1_0_0};
            mips_pkg::op_beq:   return {2'b00, 13'b0_0_0_0_0_1_0_0_0_1_0_0_0};
            // jal also raises the jump flag
            mips_pkg::op_jal:   return {2'b01, 13'b1_0_0_0_0_0_0_0_1_0_0_0_0};
            mips_pkg::op_special: begin
                if (w[5:0] == mips_pkg::fn_addu) return {2'b00, 13'b1_0_0_0_0_0_0_1_0_0_0_0_0};
                if (w[5:0] == mips_pkg::fn_subu) return {2'b00, 13'b1_0_0_0_0_1_0_1_0_0_0_0_0};
                if (w[5:0] == mips_pkg::fn_jr) return {2'b00, 13'b0_0_0_0_0_0_0_0_0_0_0_0_1};
            end
            mips_pkg::op_regimm: begin
                if (w[20:16] == mips_pkg::rt_bgez) return {2'b00, 13'b0_0_0_0_0_0_0_0_0_0_0_1_0};
            end
            default: ;
        endcase
        // unsupported, illegal with no control bits
        return 15'h4000;
    endfunction

    // reset, load prog, then run while checking each decoded word
    // stall held over cycles [stall_from, stall_to)
    // redirect to redir_to fires after the word at redir_pc decodes, -1 for none
    task automatic run_sequence(input string name, input int stall_from, input int stall_to,
                                input int redir_pc, input int redir_to, input int n_expect);
        int          cycle;
        int          next;
        int          got;
        logic        stalled;
        logic        fire;
        logic [14:0] e;
        logic [31:0] w;
        logic [15:0] bt;
        @(posedge clk);
        reset <= 1'b1;
        run <= 1'b0;
        stall <= 1'b0;
        redirect <= 1'b0;
        @(posedge clk);
        reset <= 1'b0;
        foreach (prog[i]) begin
            @(posedge clk);
            load_valid <= 1'b1;
            load_addr <= PC_WIDTH'(i);
            load_data <= prog[i];
        end
        @(posedge clk);
        load_valid <= 1'b0;
        cycle = 0;
        next = 0;
        got = 0;
        stalled = 1'b0;
        fire = 1'b0;
        while (got < n_expect && cycle < TIMEOUT) begin
            @(posedge clk);
            run <= 1'b1;
            stall <= (cycle >= stall_from && cycle < stall_to);
            redirect <= fire;
            redirect_target <= PC_WIDTH'(redir_to);
            // outputs settled by the falling edge
            @(negedge clk);
            fire = 1'b0;
            if (dec_valid) begin
                if (stalled) begin
                    errors++;
                    $display("%s: dec_valid went high while stall was held", name);
                end
                w = prog[next];
                e = expected_decode(w);
                // pc + 1 + offset, wraps at the store size
                bt = 16'(next) + 16'd1 + w[15:0];
                check_pc("dec_pc", PC_WIDTH'(next), dec_pc);
                check_fields("dec.fields", {w[31:26], w[25:21], w[20:16], w[15:11],
                                            w[5:0], w[15:0], w[25:0]}, dec.fields);
                check_ctrl("dec.ctrl", e[12:0], dec.ctrl);
                check_bit("dec.illegal", e[14], dec.illegal);
                check_bit("dec.jump", e[13], dec.jump);
                check_pc("branch_target", bt[PC_WIDTH-1:0], branch_target);
                check_pc("jump_target", w[PC_WIDTH-1:0], jump_target);
                fire = (next == redir_pc);
                // two older words drain, the one fetched with the redirect is squashed
                if (redir_pc >= 0 && next == redir_pc + 2) next = redir_to;
                else next = next + 1;
                got++;
            end
            stalled = (cycle >= stall_from && cycle < stall_to);
            cycle++;
        end
        if (got < n_expect) begin
            errors++;
            $display("%s: timed out with %0d of %0d instructions decoded", name, got, n_expect);
        end
    endtask

    // random R-type and I-type words
    task automatic test_fields();
        prog.delete();
        for (int i = 0; i < 8; i++) begin
            prog.push_back({mips_pkg::op_special, 5'(rand_bits(5)), 5'(rand_bits(5)),
                            5'(rand_bits(5)), 5'd0, 6'(rand_bits(6))});
            prog.push_back({mips_pkg::op_addiu, 5'(rand_bits(5)), 5'(rand_bits(5)),
                            16'(rand_bits(16))});
        end
        run_sequence("fields", 0, 0, -1, 0, 16);
    endtask

    // one of each supported instruction, then nop
    task automatic test_ctrl();
        prog.delete();
        prog.push_back({mips_pkg::op_addiu, 5'd4, 5'd5, 16'h0010});
        prog.push_back({mips_pkg::op_lui, 5'd0, 5'd8, 16'h1234});
        prog.push_back({mips_pkg::op_lbu, 5'd29, 5'd2, 16'hfffc});
        prog.push_back({mips_pkg::op_sb, 5'd29, 5'd3, 16'h0004});
        prog.push_back({mips_pkg::op_bgtz, 5'd6, 5'd0, 16'h0003});
        prog.push_back({mips_pkg::op_beq, 5'd0, 5'd0, 16'hfffe});
        prog.push_back({mips_pkg::op_regimm, 5'd7, mips_pkg::rt_bgez, 16'h0005});
        prog.push_back({mips_pkg::op_jal, 26'h0000040});
        prog.push_back({mips_pkg::op_special, 5'd1, 5'd2, 5'd3, 5'd0, mips_pkg::fn_addu});
        prog.push_back({mips_pkg::op_special, 5'd1, 5'd2, 5'd3, 5'd0, mips_pkg::fn_subu});
        prog.push_back({mips_pkg::op_special, 5'd31, 15'd0, mips_pkg::fn_jr});
        prog.push_back(32'h0);
        run_sequence("ctrl", 0, 0, -1, 0, 12);
    endtask

    // j, lw, all-ones, add, sll, bltz, bgezal
    task automatic test_illegal();
        prog.delete();
        prog.push_back({6'b000010, 26'h0000123});
        prog.push_back({6'b100011, 5'd1, 5'd2, 16'h0008});
        prog.push_back(32'hffff_ffff);
        prog.push_back({mips_pkg::op_special, 5'd1, 5'd2, 5'd3, 5'd0, 6'b100000});
        prog.push_back({mips_pkg::op_special, 5'd0, 5'd2, 5'd3, 5'd4, 6'b000000});
        prog.push_back({mips_pkg::op_regimm, 5'd3, 5'b00000, 16'h0010});
        prog.push_back({mips_pkg::op_regimm, 5'd3, 5'b10001, 16'h0002});
        run_sequence("illegal", 0, 0, -1, 0, 7);
    endtask

    // random branch offsets and jal indexes
    task automatic test_targets();
        prog.delete();
        for (int i = 0; i < 4; i++) begin
            prog.push_back({mips_pkg::op_beq, 10'(rand_bits(10)), 16'(rand_bits(16))});
            prog.push_back({mips_pkg::op_bgtz, 5'(rand_bits(5)), 5'd0, 16'(rand_bits(16))});
            prog.push_back({mips_pkg::op_regimm, 5'(rand_bits(5)), mips_pkg::rt_bgez,
                            16'(rand_bits(16))});
            prog.push_back({mips_pkg::op_jal, 26'(rand_bits(26))});
        end
        run_sequence("targets", 0, 0, -1, 0, 16);
    endtask

    // sequential addiu stream under stall, then under redirect
    task automatic test_flow();
        prog.delete();
        for (int i = 0; i < 20; i++) begin
            prog.push_back({mips_pkg::op_addiu, 10'(rand_bits(10)), 16'(rand_bits(16))});
        end
        run_sequence("stall", 6, 11, -1, 0, 12);
        run_sequence("redirect", 0, 0, 3, 12, 10);
    endtask

    initial begin
        reset = 1'b1;
        load_valid = 1'b0;
        load_addr = '0;
        load_data = '0;
        run = 1'b0;
        stall = 1'b0;
        redirect = 1'b0;
        redirect_target = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        test_fields();
        test_ctrl();
        test_illegal();
        test_targets();
        test_flow();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: mips_front_end.f
rtl/mips_pkg.sv
rtl/pc_unit.sv
rtl/instr_mem.sv
rtl/ifid_stage.sv
rtl/decode_unit.sv
rtl/mips_front_end.sv
verification/mips_front_end_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the log
verilator --binary --timing --assert --timescale 1ns/10ps \
    -f mips_front_end.f --top-module mips_front_end_tb -o mips_front_end_sim \
    && ./obj_dir/mips_front_end_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -qx "Finished with no errors" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
